// ==== build.f ====
+incdir+sim
hw/ldpc_enc_pkg.sv
hw/ldpc_enc_cnt.sv
hw/ldpc_enc_ctrl.sv
hw/ldpc_enc_acu.sv
hw/ldpc_enc_out.sv
hw/ldpc_enc_top.sv
sim/tb_ldpc_enc.sv

// ==== sim/tb_ldpc_enc_model.svh ====
// ldpc encoder reference model
`ifndef TB_LDPC_ENC_MODEL_SVH
`define TB_LDPC_ENC_MODEL_SVH

// four info words, whole block of eight
typedef logic [3:0][7:0] info_t;
typedef logic [7:0][7:0] blk_t;

int    n_tests   = 0;
int    n_errors  = 0;
int    errs_at_start;
string test_name = "reset";

//--------------------------------------------------------------------------
// reference encoder
//--------------------------------------------------------------------------

// bit b lands at (b + s) mod 8
function automatic logic [7:0] rot_left(input logic [7:0] w, input int s);
  logic [7:0] r;
  for (int b = 0; b < 8; b++) begin
    r[(b + s) % 8] = w[b];
  end
  return r;
endfunction

// systematic part first, then the dual-diagonal parity chain
function automatic blk_t encode_block(input info_t u);
  blk_t       blk;
  logic [7:0] acc [4];
  logic [7:0] p;
  p = '0;
  for (int i = 0; i < 4; i++) begin
    acc[i] = '0;
  end
  for (int j = 0; j < 4; j++) begin
    blk[j] = u[j];
    for (int i = 0; i < 4; i++) begin
      // anti-diagonal entries are empty
      if ((i + j) % 4 != 3) begin
        acc[i] = acc[i] ^ rot_left(u[j], (3 * i + 5 * j) % 8);
      end
    end
  end
  for (int i = 0; i < 4; i++) begin
    p          = (i == 0) ? acc[0] : (rot_left(p, 1) ^ acc[i]);
    blk[4 + i] = p;
  end
  return blk;
endfunction

//--------------------------------------------------------------------------
// error bookkeeping
//--------------------------------------------------------------------------

task automatic note_mismatch(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
  n_errors++;
  $display("ERR %s: %s expected %0h actual %0h", test_name, what, exp, act);
endtask

task automatic note_failure(input string msg);
  n_errors++;
  $display("error in %s: %s", test_name, msg);
endtask

`endif

// ==== sim/tb_ldpc_enc.sv ====
// ldpc encoder testbench
`timescale 1ns/1ns

module tb_ldpc_enc;

  import ldpc_enc_pkg::*;
  `include "tb_ldpc_enc_model.svh"

  // reset 10, five blocks at 40, stall 100, idle and margin
  localparam int c_max_cycles = 600;

  logic       iclk        = 1'b0;
  logic       ireset      = 1'b1;
  logic       irbuf_full  = 1'b0;
  word_t      irdat       = '0;
  tag_t       irtag       = '0;
  logic       iwbuf_empty = 1'b0;
  logic       orempty;
  logic [1:0] oraddr;
  logic       owrite;
  logic       owfull;
  logic [2:0] owaddr;
  word_t      owdat;
  tag_t       owtag;

  info_t      rbuf        = '0;
  logic       load        = 1'b0;
  logic       hold_out    = 1'b0;
  int         seed        = 19;
  int         cycles      = 0;
  int         blocks_done = 0;
  // block stage, S0 to S9, 10 means idle
  logic [3:0] stg;
  logic [3:0] widx;
  blk_t       exp_cur, exp_next;
  tag_t       tag_cur, tag_next;
  word_t      exp_dat;

  ldpc_enc_top UUT (.*);

  always #10 iclk = ~iclk;

  //--------------------------------------------------------------------------
  // buffer models
  //--------------------------------------------------------------------------

  // read data one cycle after the address, released by orempty
  always @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      irbuf_full <= 1'b0;
      irdat      <= '0;
    end
    else begin
      irdat <= rbuf[oraddr];
      if (orempty) irbuf_full <= 1'b0;
      else if (load) irbuf_full <= 1'b1;
    end
  end

  // output buffer drained right after owfull unless held
  always @(posedge iclk or posedge ireset) begin
    if (ireset) iwbuf_empty <= 1'b0;
    else iwbuf_empty <= !(owfull || hold_out);
  end

  //--------------------------------------------------------------------------
  // stage tracker and checks
  //--------------------------------------------------------------------------

  // block may start from S9 on, expected data latched at start
  always @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      stg <= 4'd10;
    end
    else if (stg >= 4'd9 && irbuf_full && iwbuf_empty) begin
      stg     <= 4'd0;
      exp_cur <= exp_next;
      tag_cur <= tag_next;
    end
    else if (stg < 4'd10) begin
      stg <= stg + 4'd1;
    end
  end

  always @(posedge iclk) begin
    if (!ireset && owfull) blocks_done <= blocks_done + 1;
  end

  assign widx    = stg - 4'd2;
  assign exp_dat = exp_cur[widx[2:0]];

  a_quiet : assert property (@(posedge iclk) disable iff (ireset)
    (stg == 4'd10 || stg < 4'd2) |-> !owrite && !owfull)
    else note_failure("write strobe seen outside a block");
  a_hold : assert property (@(posedge iclk) disable iff (ireset)
    stg == 4'd10 |-> $stable(oraddr))
    else note_failure("read address moved while idle");
  a_raddr : assert property (@(posedge iclk) disable iff (ireset)
    stg < 4'd4 |-> oraddr == stg[1:0])
    else note_mismatch("oraddr", $sampled(stg), $sampled(oraddr));
  a_rempty : assert property (@(posedge iclk) disable iff (ireset)
    orempty == (stg == 4'd5))
    else note_mismatch("orempty", $sampled(stg == 4'd5), $sampled(orempty));
  a_full : assert property (@(posedge iclk) disable iff (ireset)
    owfull == (stg == 4'd9))
    else note_mismatch("owfull", $sampled(stg == 4'd9), $sampled(owfull));
  a_wen : assert property (@(posedge iclk) disable iff (ireset)
    (stg >= 4'd2 && stg <= 4'd9) |-> owrite)
    else note_failure("write missing inside a block");
  a_waddr : assert property (@(posedge iclk) disable iff (ireset)
    (stg >= 4'd2 && stg <= 4'd9) |-> owaddr == widx[2:0])
    else note_mismatch("owaddr", $sampled(widx), $sampled(owaddr));
  a_wdat : assert property (@(posedge iclk) disable iff (ireset)
    (stg >= 4'd2 && stg <= 4'd9) |-> owdat == exp_dat)
    else note_mismatch("owdat", $sampled(exp_dat), $sampled(owdat));
  a_tag : assert property (@(posedge iclk) disable iff (ireset)
    owrite |-> owtag == tag_cur)
    else note_mismatch("owtag", $sampled(tag_cur), $sampled(owtag));

  //--------------------------------------------------------------------------
  // stimulus
  //--------------------------------------------------------------------------

  // waits for the input buffer to be released, then fills it
  task automatic load_block(input tag_t tag);
    info_t u;
    while (irbuf_full || load) @(posedge iclk);
    for (int k = 0; k < 4; k++) begin
      u[k] = word_t'($random(seed));
    end
    rbuf     <= u;
    irtag    <= tag;
    exp_next <= encode_block(u);
    tag_next <= tag;
    load     <= 1'b1;
    @(posedge iclk);
    load     <= 1'b0;
  endtask

  task automatic wait_blocks(input int n);
    while (blocks_done < n) @(posedge iclk);
  endtask

  task automatic start_test(input string name);
    test_name     = name;
    errs_at_start = n_errors;
    n_tests++;
  endtask

  task automatic finish_test();
    $display("test %-14s %s, %0d errors", test_name,
             (n_errors == errs_at_start) ? "ok" : "FAILED", n_errors - errs_at_start);
  endtask

  always @(posedge iclk) begin
    cycles <= cycles + 1;
    if (cycles >= c_max_cycles) begin
      $display("timeout, run stopped after %0d cycles", cycles);
      $display("sim failed");
      $finish;
    end
  end

  initial begin
    int n0;
    repeat (10) @(posedge iclk);
    ireset <= 1'b0;

    start_test("idle_reset");
    repeat (20) @(posedge iclk);
    finish_test();

    start_test("single_block");
    n0 = blocks_done;
    load_block(4'h3);
    wait_blocks(n0 + 1);
    finish_test();

    // input ready but output buffer busy for 100 cycles
    start_test("stall");
    hold_out <= 1'b1;
    @(posedge iclk);
    n0 = blocks_done;
    load_block(4'h9);
    repeat (100) @(posedge iclk);
    a_no_start : assert (blocks_done == n0)
      else note_failure("block ran while output buffer was not empty");
    hold_out <= 1'b0;
    wait_blocks(n0 + 1);
    finish_test();

    start_test("back_to_back");
    n0 = blocks_done;
    for (int b = 0; b < 5; b++) begin
      load_block(tag_t'(3 * b + 1));
    end
    wait_blocks(n0 + 5);
    finish_test();

    repeat (4) @(posedge iclk);
    $display("tests %0d, blocks %0d, errors %0d", n_tests, blocks_done, n_errors);
    if (n_errors == 0) begin
      $display("sim passed");
    end
    else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== hw/ldpc_enc_top.sv ====
// ldpc encoder engine top
`timescale 1ns/1ns

module ldpc_enc_top (
  input  logic                               iclk,
  input  logic                               ireset,
  // input buffer side
  input  logic                               irbuf_full,
  input  ldpc_enc_pkg::word_t                irdat,
  input  ldpc_enc_pkg::tag_t                 irtag,
  output logic                               orempty,
  output logic [ldpc_enc_pkg::c_raddr_w-1:0] oraddr,
  // output buffer side
  input  logic                               iwbuf_empty,
  output logic                               owrite,
  output logic                               owfull,
  output logic [ldpc_enc_pkg::c_waddr_w-1:0] owaddr,
  output ldpc_enc_pkg::word_t                owdat,
  output ldpc_enc_pkg::tag_t                 owtag
);

  import ldpc_enc_pkg::*;

  logic     cnt_clear;
  logic     cnt_enable;
  col_t     idx;
  logic     last;
  acu_ctl_t acu_ctl;
  wr_t      wr;

  //--------------------------------------------------------------------------
  // word counter
  //--------------------------------------------------------------------------

  ldpc_enc_cnt u_cnt (
    .iclk   (iclk),
    .ireset (ireset),
    .clear  (cnt_clear),
    .enable (cnt_enable),
    .idx    (idx),
    .last   (last)
  );

  //--------------------------------------------------------------------------
  // sequencer
  //--------------------------------------------------------------------------

  ldpc_enc_ctrl u_ctrl (
    .iclk        (iclk),
    .ireset      (ireset),
    .irbuf_full  (irbuf_full),
    .iwbuf_empty (iwbuf_empty),
    .idx         (idx),
    .last        (last),
    .cnt_clear   (cnt_clear),
    .cnt_enable  (cnt_enable),
    .oraddr      (oraddr),
    .orempty     (orempty),
    .acu_ctl     (acu_ctl)
  );

  //--------------------------------------------------------------------------
  // A*u' and parity chain
  //--------------------------------------------------------------------------

  // read data taken straight from the input buffer
  ldpc_enc_acu u_acu (
    .iclk   (iclk),
    .ireset (ireset),
    .ctl    (acu_ctl),
    .irdat  (irdat),
    .wr     (wr)
  );

  //--------------------------------------------------------------------------
  // output port
  //--------------------------------------------------------------------------

  ldpc_enc_out u_out (
    .iclk   (iclk),
    .ireset (ireset),
    .wr     (wr),
    .irtag  (irtag),
    .owrite (owrite),
    .owfull (owfull),
    .owaddr (owaddr),
    .owdat  (owdat),
    .owtag  (owtag)
  );

endmodule

// ==== hw/ldpc_enc_out.sv ====
// ldpc encoder output write port
`timescale 1ns/1ns

module ldpc_enc_out (
  input  logic                               iclk,
  input  logic                               ireset,
  input  ldpc_enc_pkg::wr_t                  wr,
  input  ldpc_enc_pkg::tag_t                 irtag,
  output logic                               owrite,
  output logic                               owfull,
  output logic [ldpc_enc_pkg::c_waddr_w-1:0] owaddr,
  output ldpc_enc_pkg::word_t                owdat,
  output ldpc_enc_pkg::tag_t                 owtag
);

  import ldpc_enc_pkg::*;

  //--------------------------------------------------------------------------
  // strobes and address
  //--------------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      owrite <= 1'b0;
      owfull <= 1'b0;
      owaddr <= '0;
    end
    else begin
      owrite <= wr.val;
      // block done with its last parity word
      owfull <= wr.val & wr.eof;
      // restart at the first info word
      if (wr.val & wr.sof) begin
        owaddr <= '0;
      end
      else if (wr.val) begin
        owaddr <= owaddr + 1'b1;
      end
    end
  end

  //--------------------------------------------------------------------------
  // data and tag
  //--------------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (wr.val) begin
      owdat <= wr.dat;
    end
    // input tag still valid at the first word
    if (wr.val & wr.sof) begin
      owtag <= irtag;
    end
  end

  // full only with the write of the last block word
  a_full_last : assert property (
    @(posedge iclk) disable iff (ireset)
    owfull |-> owrite && (owaddr == c_waddr_w'(c_nb - 1))
  );

endmodule

// ==== hw/ldpc_enc_acu.sv ====
// ldpc encoder accumulators and parity chain
`timescale 1ns/1ns

module ldpc_enc_acu (
  input  logic                   iclk,
  input  logic                   ireset,
  input  ldpc_enc_pkg::acu_ctl_t ctl,
  input  ldpc_enc_pkg::word_t    irdat,
  output ldpc_enc_pkg::wr_t      wr
);

  import ldpc_enc_pkg::*;

  // left cyclic shift of one circulant
  function automatic word_t rotl(input word_t w, input int s);
    logic [2*c_zc-1:0] dbl;
    dbl = {w, w} >> (c_zc - s);
    return dbl[c_zc-1:0];
  endfunction

  // column in info phase, row in parity phase
  logic [$clog2(c_kb)-1:0] sel;

  word_t acc [c_mb];
  word_t par_prev;
  word_t par_fb;
  word_t par_dat;
  logic  par_busy;
  logic  par_last;

  assign sel      = ctl.col[$clog2(c_kb)-1:0];
  assign par_last = ctl.par_val & (ctl.col == col_t'(c_mb - 1));

  //--------------------------------------------------------------------------
  // A*u' row accumulators
  //--------------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (ctl.clear) begin
      for (int i = 0; i < c_mb; i++) begin
        acc[i] <= '0;
      end
    end
    else if (ctl.info_val) begin
      // every connected row folds in the rotated word
      for (int i = 0; i < c_mb; i++) begin
        if (c_hb_shift[i][sel] != c_hb_none) begin
          acc[i] <= acc[i] ^ rotl(irdat, c_hb_shift[i][sel]);
        end
      end
    end
  end

  //--------------------------------------------------------------------------
  // dual diagonal parity chain
  //--------------------------------------------------------------------------

  // high after row 0 until the last row is out
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      par_busy <= 1'b0;
    end
    else if (ctl.par_val) begin
      par_busy <= ~par_last;
    end
  end

  // row 0 has no previous parity
  assign par_fb  = par_busy ? rotl(par_prev, c_psi_shift) : '0;
  assign par_dat = par_fb ^ acc[sel];

  always_ff @(posedge iclk) begin
    if (ctl.par_val) begin
      par_prev <= par_dat;
    end
  end

  //--------------------------------------------------------------------------
  // write stream
  //--------------------------------------------------------------------------

  // info words go out unchanged
  always_comb begin
    wr.val = ctl.info_val | ctl.par_val;
    wr.sof = ctl.info_val & (ctl.col == '0);
    wr.eof = par_last;
    wr.dat = ctl.par_val ? par_dat : irdat;
  end

  // parity rows run back to back with no info word mixed in
  a_par_clean : assert property (
    @(posedge iclk) disable iff (ireset)
    par_busy |-> ctl.par_val && !ctl.info_val
  );

endmodule

// ==== hw/ldpc_enc_ctrl.sv ====
// ldpc encoder block sequencer
`timescale 1ns/1ns

module ldpc_enc_ctrl (
  input  logic                               iclk,
  input  logic                               ireset,
  input  logic                               irbuf_full,
  input  logic                               iwbuf_empty,
  input  ldpc_enc_pkg::col_t                 idx,
  input  logic                               last,
  output logic                               cnt_clear,
  output logic                               cnt_enable,
  output logic [ldpc_enc_pkg::c_raddr_w-1:0] oraddr,
  output logic                               orempty,
  output ldpc_enc_pkg::acu_ctl_t             acu_ctl
);

  import ldpc_enc_pkg::*;

  typedef enum logic [1:0] {st_idle, st_read, st_drain, st_parity} state_t;

  state_t state;
  state_t state_nxt;
  logic   start;
  logic   par_phase;
  // read strobe aligned to buffer latency
  logic   info_d;
  col_t   col_d;

  //--------------------------------------------------------------------------
  // fsm
  //--------------------------------------------------------------------------

  // both buffers ready while idle
  assign start = (state == st_idle) & irbuf_full & iwbuf_empty;

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle   : if (start) state_nxt = st_read;
      st_read   : if (last)  state_nxt = st_drain;
      // last word still in flight from the buffer
      st_drain  : state_nxt = st_parity;
      st_parity : if (last)  state_nxt = st_idle;
      default   : state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state   <= st_idle;
      info_d  <= 1'b0;
      col_d   <= '0;
      orempty <= 1'b0;
    end
    else begin
      state   <= state_nxt;
      info_d  <= (state == st_read);
      col_d   <= idx;
      // release input buffer once all words are in
      orempty <= (state == st_drain);
    end
  end

  // counter held at zero while idle and between phases
  assign cnt_clear  = (state == st_idle) |
                      (((state == st_read) | (state == st_parity)) & last);
  assign cnt_enable = (state == st_read) | (state == st_parity);

  assign oraddr     = idx[c_raddr_w-1:0];

  //--------------------------------------------------------------------------
  // acu strobes
  //--------------------------------------------------------------------------

  assign par_phase = (state == st_parity);

  always_comb begin
    acu_ctl.clear    = start;
    acu_ctl.info_val = info_d;
    acu_ctl.par_val  = par_phase;
    // row index in parity, delayed column in info
    acu_ctl.col      = par_phase ? idx : col_d;
  end

  // input buffer holds its block until released
  a_rbuf_held : assert property (
    @(posedge iclk) disable iff (ireset)
    (state == st_read) || (state == st_drain) |-> irbuf_full
  );

endmodule

// ==== hw/ldpc_enc_cnt.sv ====
// ldpc encoder word counter
`timescale 1ns/1ns

module ldpc_enc_cnt (
  input  logic               iclk,
  input  logic               ireset,
  input  logic               clear,
  input  logic               enable,
  output ldpc_enc_pkg::col_t idx,
  output logic               last
);

  import ldpc_enc_pkg::*;

  //--------------------------------------------------------------------------
  // word index
  //--------------------------------------------------------------------------

  // shared by read and parity phases
  // clear wins over enable
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      idx <= '0;
    end
    else if (clear) begin
      idx <= '0;
    end
    else if (enable) begin
      idx <= idx + 1'b1;
    end
  end

  // last word of a phase
  // both phases are four words long
  assign last = (idx == col_t'(c_kb - 1));

  //--------------------------------------------------------------------------
  // checks
  //--------------------------------------------------------------------------

  // ctrl must clear before the index would wrap
  a_no_wrap : assert property (
    @(posedge iclk) disable iff (ireset)
    enable && !clear |-> idx != col_t'(c_nb - 1)
  );

endmodule

// ==== hw/ldpc_enc_pkg.sv ====
// ldpc encoder shared definitions
package ldpc_enc_pkg;

  //--------------------------------------------------------------------------
  // sizes and addresses
  //--------------------------------------------------------------------------

  // bits per word, one word holds one circulant
  localparam int c_zc        = 8;
  // information columns of the base matrix
  localparam int c_kb        = 4;
  // parity rows of the base matrix
  localparam int c_mb        = 4;
  // whole block in words
  localparam int c_nb        = c_kb + c_mb;

  localparam int c_raddr_w   = 2;
  localparam int c_waddr_w   = 3;
  localparam int c_tag_w     = 4;

  // rotation of the previous parity word in the chain
  localparam int c_psi_shift = 1;

  //--------------------------------------------------------------------------
  // base matrix
  //--------------------------------------------------------------------------

  // no connection marker
  localparam int c_hb_none   = -1;

  // shift (3*i + 5*j) mod 8
  // cleared where (i + j) mod 4 == 3
  localparam int c_hb_shift [c_mb][c_kb] = '{
    '{0,         5,         2,         c_hb_none},
    '{3,         0,         c_hb_none, 2        },
    '{6,         c_hb_none, 0,         5        },
    '{c_hb_none, 6,         3,         0        }
  };

  //--------------------------------------------------------------------------
  // types
  //--------------------------------------------------------------------------

  typedef logic [c_zc-1:0]         word_t;
  typedef logic [$clog2(c_nb)-1:0] col_t;
  typedef logic [c_tag_w-1:0]      tag_t;

  // ctrl to acu strobes
  typedef struct packed {
    logic clear;
    logic info_val;
    col_t col;
    logic par_val;
  } acu_ctl_t;

  // acu to output port
  typedef struct packed {
    logic  val;
    logic  sof;
    logic  eof;
    word_t dat;
  } wr_t;

endpackage
